/* dv/dcache_vectors.txt */
// op(0 load 1 store) align(0 B 1 H 2 W 3 BU 4 HU) addr wdata expected_rdata
// byte at a = xor of all address bytes ^ 5a; misaligned rows expect zero data
0 2 00000100 00000000 58595a5b
0 0 00000185 00000000 ffffffde
0 3 00000185 00000000 000000de
0 1 00000186 00000000 ffffdcdd
0 4 00000186 00000000 0000dcdd
1 2 00000104 12345678 00000000
1 0 00000105 000000ab 00000000
1 1 00000106 0000fe01 00000000
0 2 00000104 00000000 fe01ab78
0 0 00000105 00000000 ffffffab
0 3 00000107 00000000 000000fe
0 1 00000106 00000000 fffffe01
0 4 00000104 00000000 0000ab78
0 2 00000200 00000000 5b5a5958
0 2 00000104 00000000 fe01ab78
0 1 00000109 00000000 00000000
1 2 0000010a deadbeef 00000000
0 2 00000108 00000000 50515253
0 4 0000010a 00000000 00005051

/* compile.f */
+incdir+include
logic/dcache_pkg.sv
logic/dcache_req_stage.sv
logic/dcache_arrays.sv
logic/dcache_miss_ctrl.sv
logic/dcache_top.sv
dv/dcache_assert.sv
dv/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module dcache_tb \
  --Mdir obj_dir -o dcache_sim \
  && ./obj_dir/dcache_sim | tee sim.log \
  && grep -q "Finished with no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* dv/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_tb;
  import dcache_pkg::*;

  localparam int  NUM_VEC    = 19;
  localparam int  FIELDS     = 5;
  localparam time CLK_PERIOD = 10;

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid_i;
  logic                  req_ready_o;
  mem_op_e               req_op_i;
  align_e                req_align_i;
  logic [`DC_ADDR_W-1:0] req_addr_i;
  logic [`DC_DATA_W-1:0] req_wdata_i;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;
  logic [`DC_DATA_W-1:0] rsp_rdata_o;
  logic                  rsp_err_o;
  logic                  mem_cmd_valid_o;
  logic                  mem_cmd_ready_i;
  logic                  mem_cmd_write_o;
  logic [`DC_ADDR_W-1:0] mem_cmd_addr_o;
  logic                  mem_wvalid_o;
  logic                  mem_wready_i;
  logic [`DC_DATA_W-1:0] mem_wdata_o;
  logic                  mem_wlast_o;
  logic                  mem_rvalid_i;
  logic [`DC_DATA_W-1:0] mem_rdata_i;
  logic                  mem_rlast_i;

  logic [31:0] vec_mem [0:NUM_VEC*FIELDS-1];
  logic [7:0]  mem_img [logic [31:0]];
  logic [7:0]  ref_img [logic [31:0]];
  logic [31:0] lfsr_state = 32'h75c6e69e;
  int          exp_q[$];
  int          rsp_count;
  int          check_count;
  int          error_count;

  dcache_top uut (.*);

  // ============================================================
  // helpers
  // ============================================================
  function automatic logic next_bit();
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    return lfsr_state[0];
  endfunction

  function automatic logic [3:0] take_bits(int n);
    logic [3:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[2:0], next_bit()};
    end
    return v;
  endfunction

  // fill pattern folds every address byte into the value
  function automatic logic [7:0] init_byte(logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] mem_byte(logic [31:0] a);
    return mem_img.exists(a) ? mem_img[a] : init_byte(a);
  endfunction

  function automatic logic [7:0] ref_byte(logic [31:0] a);
    return ref_img.exists(a) ? ref_img[a] : init_byte(a);
  endfunction

  function automatic logic misaligned(align_e al, logic [31:0] a);
    if (al == AL_H || al == AL_HU) begin
      return a[0];
    end
    if (al == AL_W) begin
      return a[1] | a[0];
    end
    return 1'b0;
  endfunction

  function automatic int access_bytes(align_e al);
    if (al == AL_W) begin
      return 4;
    end
    return (al == AL_H || al == AL_HU) ? 2 : 1;
  endfunction

  // ============================================================
  // compare tasks
  // ============================================================
  task automatic check_load(int idx, align_e al, logic [`DC_DATA_W-1:0] got,
                            logic [`DC_DATA_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: vector %0d %s rdata %h, expected %h",
               $time, idx, al.name(), got, exp);
    end
  endtask

  task automatic check_err(int idx, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: vector %0d err flag %b, expected %b", $time, idx, got, exp);
    end
  endtask

  task automatic check_beat(logic [31:0] a, logic [`DC_DATA_W-1:0] got, logic got_last,
                            logic exp_last);
    logic [`DC_DATA_W-1:0] exp;
    exp = {ref_byte(a + 3), ref_byte(a + 2), ref_byte(a + 1), ref_byte(a)};
    check_count++;
    if (got !== exp || got_last !== exp_last) begin
      error_count++;
      $display("error at %0t: write-back %h data %h last %b, expected %h last %b",
               $time, a, got, got_last, exp, exp_last);
    end
  endtask

  // ============================================================
  // clock, watchdog
  // ============================================================
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_VEC * 200 * CLK_PERIOD);
    $display("timeout: only %0d of %0d responses arrived", rsp_count, NUM_VEC);
    $display("Finished with errors");
    $finish;
  end

  // ============================================================
  // requester
  // ============================================================
  initial begin
    logic accepted;
    logic [31:0] a;
    rst_n           = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = OP_LOAD;
    req_align_i     = AL_W;
    req_addr_i      = '0;
    req_wdata_i     = '0;
    rsp_ready_i     = 1'b0;
    mem_cmd_ready_i = 1'b0;
    mem_wready_i    = 1'b0;
    mem_rvalid_i    = 1'b0;
    mem_rdata_i     = '0;
    mem_rlast_i     = 1'b0;
    rsp_count       = 0;
    check_count     = 0;
    error_count     = 0;
    $readmemh("dv/dcache_vectors.txt", vec_mem);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < NUM_VEC; i++) begin
      @(negedge clk);
      req_valid_i = 1'b1;
      req_op_i    = mem_op_e'(vec_mem[FIELDS*i][0]);
      req_align_i = align_e'(vec_mem[FIELDS*i+1][2:0]);
      req_addr_i  = vec_mem[FIELDS*i+2];
      req_wdata_i = vec_mem[FIELDS*i+3];
      forever begin
        #4;
        accepted = req_ready_o;
        @(posedge clk);
        if (accepted) begin
          break;
        end
        @(negedge clk);
      end
      exp_q.push_back(i);
      a = req_addr_i;
      if (req_op_i == OP_STORE && !misaligned(req_align_i, a)) begin
        for (int b = 0; b < access_bytes(req_align_i); b++) begin
          ref_img[a + b] = req_wdata_i[8*b +: 8];
        end
      end
    end
    @(negedge clk);
    req_valid_i = 1'b0;
    while (rsp_count < NUM_VEC) begin
      @(negedge clk);
    end
    // room for a stray extra response
    repeat (20) @(negedge clk);
    $display("responses %0d of %0d, checks %0d, errors %0d",
             rsp_count, NUM_VEC, check_count, error_count);
    if (error_count == 0 && rsp_count == NUM_VEC) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // ============================================================
  // response side with random back-pressure
  // ============================================================
  initial begin
    int     idx;
    align_e al;
    int     err_before;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      rsp_ready_i = next_bit() | next_bit();
      #4;
      if (rsp_valid_o && rsp_ready_i) begin
        rsp_count++;
        if (exp_q.size() == 0) begin
          error_count++;
          $display("a response came back with no request outstanding at %0t", $time);
        end else begin
          idx        = exp_q.pop_front();
          al         = align_e'(vec_mem[FIELDS*idx+1][2:0]);
          err_before = error_count;
          check_err(idx, rsp_err_o, misaligned(al, vec_mem[FIELDS*idx+2]));
          check_load(idx, al, rsp_rdata_o, vec_mem[FIELDS*idx+4]);
          $display("vector %0d %s %s addr %h: %s", idx,
                   vec_mem[FIELDS*idx][0] ? "store" : "load", al.name(),
                   vec_mem[FIELDS*idx+2], (error_count == err_before) ? "ok" : "mismatch");
        end
      end
    end
  end

  // ============================================================
  // memory bus responder
  // ============================================================
  initial begin
    logic        is_wr;
    logic [31:0] base;
    int          k;
    int          dly;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      mem_cmd_ready_i = next_bit();
      mem_wready_i    = 1'b0;
      mem_rvalid_i    = 1'b0;
      mem_rlast_i     = 1'b0;
      #4;
      if (mem_cmd_valid_o && mem_cmd_ready_i) begin
        is_wr = mem_cmd_write_o;
        base  = mem_cmd_addr_o;
        @(posedge clk);
        k = 0;
        while (is_wr && k < `DC_WORDS_PER_LINE) begin
          @(negedge clk);
          mem_cmd_ready_i = 1'b0;
          mem_wready_i    = next_bit();
          #4;
          if (mem_wvalid_o && mem_wready_i) begin
            check_beat(base + 4 * k, mem_wdata_o, mem_wlast_o, k == `DC_WORDS_PER_LINE - 1);
            for (int b = 0; b < 4; b++) begin
              mem_img[base + 4 * k + b] = mem_wdata_o[8*b +: 8];
            end
            k++;
          end
          @(posedge clk);
        end
        for (k = 0; !is_wr && k < `DC_WORDS_PER_LINE; k++) begin
          @(negedge clk);
          mem_cmd_ready_i = 1'b0;
          mem_rvalid_i    = 1'b0;
          dly             = take_bits(2);
          repeat (dly) @(negedge clk);
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = {mem_byte(base + 4 * k + 3), mem_byte(base + 4 * k + 2),
                          mem_byte(base + 4 * k + 1), mem_byte(base + 4 * k)};
          mem_rlast_i  = (k == `DC_WORDS_PER_LINE - 1);
          @(posedge clk);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/dcache_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_assert (
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire logic                      rsp_valid_o,
  input wire logic                      rsp_ready_i,
  input wire logic [`DC_DATA_W-1:0]     rsp_rdata_o,
  input wire logic                      rsp_err_o,
  input wire logic                      mem_cmd_valid_o,
  input wire logic                      mem_cmd_ready_i,
  input wire logic                      mem_cmd_write_o,
  input wire logic [`DC_ADDR_W-1:0]     mem_cmd_addr_o,
  input wire logic                      mem_wvalid_o,
  input wire logic                      mem_wready_i,
  input wire logic                      mem_wlast_o,
  input wire dcache_pkg::miss_state_e   ms_state
);
  import dcache_pkg::*;

  logic wr_open;

  // open from an accepted write command until its last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_open <= 1'b0;
    end else if (mem_cmd_valid_o && mem_cmd_ready_i && mem_cmd_write_o) begin
      wr_open <= 1'b1;
    end else if (mem_wvalid_o && mem_wready_i && mem_wlast_o) begin
      wr_open <= 1'b0;
    end
  end

  // stalled response keeps its fields
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o))
    else $error("response changed while stalled");

  cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_cmd_valid_o && !mem_cmd_ready_i |=>
      mem_cmd_valid_o && $stable(mem_cmd_addr_o) && $stable(mem_cmd_write_o))
    else $error("memory command dropped before acceptance");

  // write beats only after a write command
  wbeat_in_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    mem_wvalid_o |-> wr_open)
    else $error("write beat outside a write command");

  rcmd_after_wb: assert property (@(posedge clk) disable iff (!rst_n)
    mem_cmd_valid_o && !mem_cmd_write_o |-> !wr_open)
    else $error("read command before the write-back finished");

  rsp_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |-> ms_state == MS_IDLE)
    else $error("response offered while a miss is in progress");

endmodule

bind dcache_top dcache_assert u_assert (.*, .ms_state(u_miss_ctrl.state_q));

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // requester side
  input  wire logic                  req_valid_i,
  output logic                       req_ready_o,
  input  wire dcache_pkg::mem_op_e   req_op_i,
  input  wire dcache_pkg::align_e    req_align_i,
  input  wire logic [`DC_ADDR_W-1:0] req_addr_i,
  input  wire logic [`DC_DATA_W-1:0] req_wdata_i,
  output logic                       rsp_valid_o,
  input  wire logic                  rsp_ready_i,
  output logic [`DC_DATA_W-1:0]      rsp_rdata_o,
  output logic                       rsp_err_o,
  // memory bus
  output logic                       mem_cmd_valid_o,
  input  wire logic                  mem_cmd_ready_i,
  output logic                       mem_cmd_write_o,
  output logic [`DC_ADDR_W-1:0]      mem_cmd_addr_o,
  output logic                       mem_wvalid_o,
  input  wire logic                  mem_wready_i,
  output logic [`DC_DATA_W-1:0]      mem_wdata_o,
  output logic                       mem_wlast_o,
  input  wire logic                  mem_rvalid_i,
  input  wire logic [`DC_DATA_W-1:0] mem_rdata_i,
  input  wire logic                  mem_rlast_i
);

  // ============================================================
  // internal nets
  // ============================================================
  logic [`DC_IDX_W-1:0]                          lookup_idx;
  logic [`DC_TAG_W-1:0]                          line_tag;
  logic                                          line_valid;
  logic                                          line_dirty;
  logic [`DC_WORDS_PER_LINE-1:0][`DC_DATA_W-1:0] line_data;
  logic                                          hit_we;
  logic [`DC_OFS_W-3:0]                          hit_word;
  logic [`DC_DATA_W/8-1:0]                       hit_be;
  logic [`DC_DATA_W-1:0]                         hit_wdata;
  logic                                          miss_start;
  logic [`DC_ADDR_W-1:0]                         miss_addr;
  logic                                          miss_done;
  logic                                          fill_we;
  logic [`DC_TAG_W-1:0]                          fill_tag;
  logic [`DC_WORDS_PER_LINE-1:0][`DC_DATA_W-1:0] fill_data;

  dcache_req_stage u_req_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_align_i  (req_align_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o),
    .lookup_idx_o (lookup_idx),
    .line_tag_i   (line_tag),
    .line_valid_i (line_valid),
    .line_data_i  (line_data),
    .hit_we_o     (hit_we),
    .hit_word_o   (hit_word),
    .hit_be_o     (hit_be),
    .hit_wdata_o  (hit_wdata),
    .miss_start_o (miss_start),
    .miss_addr_o  (miss_addr),
    .miss_done_i  (miss_done)
  );

  dcache_arrays u_arrays (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookup_idx_i (lookup_idx),
    .line_tag_o   (line_tag),
    .line_valid_o (line_valid),
    .line_dirty_o (line_dirty),
    .line_data_o  (line_data),
    .hit_we_i     (hit_we),
    .hit_word_i   (hit_word),
    .hit_be_i     (hit_be),
    .hit_wdata_i  (hit_wdata),
    .fill_we_i    (fill_we),
    .fill_tag_i   (fill_tag),
    .fill_data_i  (fill_data)
  );

  // victim is whatever the arrays show at the held index
  dcache_miss_ctrl u_miss_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .miss_start_i    (miss_start),
    .miss_addr_i     (miss_addr),
    .miss_done_o     (miss_done),
    .victim_valid_i  (line_valid),
    .victim_dirty_i  (line_dirty),
    .victim_tag_i    (line_tag),
    .victim_data_i   (line_data),
    .fill_we_o       (fill_we),
    .fill_tag_o      (fill_tag),
    .fill_data_o     (fill_data),
    .mem_cmd_valid_o (mem_cmd_valid_o),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .mem_cmd_write_o (mem_cmd_write_o),
    .mem_cmd_addr_o  (mem_cmd_addr_o),
    .mem_wvalid_o    (mem_wvalid_o),
    .mem_wready_i    (mem_wready_i),
    .mem_wdata_o     (mem_wdata_o),
    .mem_wlast_o     (mem_wlast_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_rlast_i     (mem_rlast_i)
  );

endmodule

`default_nettype wire

/* logic/dcache_miss_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_miss_ctrl (
  input  wire logic                                          clk,
  input  wire logic                                          rst_n,
  input  wire logic                                          miss_start_i,
  input  wire logic [`DC_ADDR_W-1:0]                         miss_addr_i,
  output logic                                               miss_done_o,
  input  wire logic                                          victim_valid_i,
  input  wire logic                                          victim_dirty_i,
  input  wire logic [`DC_TAG_W-1:0]                          victim_tag_i,
  input  wire logic [`DC_WORDS_PER_LINE-1:0][`DC_DATA_W-1:0] victim_data_i,
  output logic                                               fill_we_o,
  output logic [`DC_TAG_W-1:0]                               fill_tag_o,
  output logic [`DC_WORDS_PER_LINE-1:0][`DC_DATA_W-1:0]      fill_data_o,
  output logic                                               mem_cmd_valid_o,
  input  wire logic                                          mem_cmd_ready_i,
  output logic                                               mem_cmd_write_o,
  output logic [`DC_ADDR_W-1:0]                              mem_cmd_addr_o,
  output logic                                               mem_wvalid_o,
  input  wire logic                                          mem_wready_i,
  output logic [`DC_DATA_W-1:0]                              mem_wdata_o,
  output logic                                               mem_wlast_o,
  input  wire logic                                          mem_rvalid_i,
  input  wire logic [`DC_DATA_W-1:0]                         mem_rdata_i,
  input  wire logic                                          mem_rlast_i
);
  import dcache_pkg::*;

  miss_state_e                                   state_q;
  logic [`DC_OFS_W-3:0]                          beat_q;
  logic                                          done_q;
  logic [`DC_ADDR_W-`DC_OFS_W-1:0]               line_q;
  logic [`DC_WORDS_PER_LINE-1:0][`DC_DATA_W-1:0] line_buf;

  // ============================================================
  // bus outputs decoded from the state
  // ============================================================
  assign mem_cmd_valid_o = (state_q == MS_WB_CMD) | (state_q == MS_RF_CMD);
  assign mem_cmd_write_o = (state_q == MS_WB_CMD);
  // victim shares the index of the missing line
  assign mem_cmd_addr_o  = (state_q == MS_WB_CMD) ?
                           {victim_tag_i, line_q[`DC_IDX_W-1:0], {`DC_OFS_W{1'b0}}} :
                           {line_q, {`DC_OFS_W{1'b0}}};
  assign mem_wvalid_o    = (state_q == MS_WB_DATA);
  assign mem_wdata_o     = victim_data_i[beat_q];
  assign mem_wlast_o     = (beat_q == (`DC_OFS_W - 2)'(`DC_WORDS_PER_LINE - 1));

  // last beat goes straight into the line, no extra buffer cycle
  assign fill_we_o   = (state_q == MS_RF_DATA) & mem_rvalid_i & mem_rlast_i;
  assign fill_tag_o  = line_q[`DC_ADDR_W-`DC_OFS_W-1:`DC_IDX_W];
  assign miss_done_o = done_q;

  always_comb begin
    for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
      fill_data_o[w] = (beat_q == (`DC_OFS_W - 2)'(w)) ? mem_rdata_i : line_buf[w];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= fill_we_o;
      case (state_q)
        MS_IDLE: begin
          beat_q <= '0;
          if (miss_start_i) begin
            // clean or empty victim skips the write-back
            state_q <= (victim_valid_i && victim_dirty_i) ? MS_WB_CMD : MS_RF_CMD;
          end
        end
        MS_WB_CMD: begin
          if (mem_cmd_ready_i) begin
            state_q <= MS_WB_DATA;
          end
        end
        MS_WB_DATA: begin
          if (mem_wready_i) begin
            beat_q <= beat_q + 1'b1;
            if (mem_wlast_o) begin
              state_q <= MS_RF_CMD;
            end
          end
        end
        MS_RF_CMD: begin
          beat_q <= '0;
          if (mem_cmd_ready_i) begin
            state_q <= MS_RF_DATA;
          end
        end
        MS_RF_DATA: begin
          if (mem_rvalid_i) begin
            beat_q <= beat_q + 1'b1;
            if (mem_rlast_i) begin
              state_q <= MS_IDLE;
            end
          end
        end
        default: state_q <= MS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == MS_IDLE && miss_start_i) begin
      line_q <= miss_addr_i[`DC_ADDR_W-1:`DC_OFS_W];
    end
    if (state_q == MS_RF_DATA && mem_rvalid_i) begin
      line_buf[beat_q] <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* logic/dcache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_arrays (
  input  wire logic                                          clk,
  input  wire logic                                          rst_n,
  input  wire logic [`DC_IDX_W-1:0]                          lookup_idx_i,
  output logic [`DC_TAG_W-1:0]                               line_tag_o,
  output logic                                               line_valid_o,
  output logic                                               line_dirty_o,
  output logic [`DC_WORDS_PER_LINE-1:0][`DC_DATA_W-1:0]      line_data_o,
  input  wire logic                                          hit_we_i,
  input  wire logic [`DC_OFS_W-3:0]                          hit_word_i,
  input  wire logic [`DC_DATA_W/8-1:0]                       hit_be_i,
  input  wire logic [`DC_DATA_W-1:0]                         hit_wdata_i,
  input  wire logic                                          fill_we_i,
  input  wire logic [`DC_TAG_W-1:0]                          fill_tag_i,
  input  wire logic [`DC_WORDS_PER_LINE-1:0][`DC_DATA_W-1:0] fill_data_i
);

  logic [`DC_TAG_W-1:0]                          tag_mem  [`DC_LINES];
  logic [`DC_WORDS_PER_LINE-1:0][`DC_DATA_W-1:0] data_mem [`DC_LINES];
  logic [`DC_LINES-1:0]                          valid_q;
  logic [`DC_LINES-1:0]                          dirty_q;

  // combinational read at the single index
  assign line_tag_o   = tag_mem[lookup_idx_i];
  assign line_valid_o = valid_q[lookup_idx_i];
  assign line_dirty_o = dirty_q[lookup_idx_i];
  assign line_data_o  = data_mem[lookup_idx_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (fill_we_i) begin
      valid_q[lookup_idx_i] <= 1'b1;
    end
  end

  // ============================================================
  // refill replaces the whole line, store hit touches one word
  // ============================================================
  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      tag_mem[lookup_idx_i]  <= fill_tag_i;
      data_mem[lookup_idx_i] <= fill_data_i;
      dirty_q[lookup_idx_i]  <= 1'b0;
    end else if (hit_we_i) begin
      for (int b = 0; b < `DC_DATA_W/8; b++) begin
        if (hit_be_i[b]) begin
          data_mem[lookup_idx_i][hit_word_i][8*b +: 8] <= hit_wdata_i[8*b +: 8];
        end
      end
      dirty_q[lookup_idx_i] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/dcache_req_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_req_stage (
  input  wire logic                                          clk,
  input  wire logic                                          rst_n,
  input  wire logic                                          req_valid_i,
  output logic                                               req_ready_o,
  input  wire dcache_pkg::mem_op_e                           req_op_i,
  input  wire dcache_pkg::align_e                            req_align_i,
  input  wire logic [`DC_ADDR_W-1:0]                         req_addr_i,
  input  wire logic [`DC_DATA_W-1:0]                         req_wdata_i,
  output logic                                               rsp_valid_o,
  input  wire logic                                          rsp_ready_i,
  output logic [`DC_DATA_W-1:0]                              rsp_rdata_o,
  output logic                                               rsp_err_o,
  output logic [`DC_IDX_W-1:0]                               lookup_idx_o,
  input  wire logic [`DC_TAG_W-1:0]                          line_tag_i,
  input  wire logic                                          line_valid_i,
  input  wire logic [`DC_WORDS_PER_LINE-1:0][`DC_DATA_W-1:0] line_data_i,
  output logic                                               hit_we_o,
  output logic [`DC_OFS_W-3:0]                               hit_word_o,
  output logic [`DC_DATA_W/8-1:0]                            hit_be_o,
  output logic [`DC_DATA_W-1:0]                              hit_wdata_o,
  output logic                                               miss_start_o,
  output logic [`DC_ADDR_W-1:0]                              miss_addr_o,
  input  wire logic                                          miss_done_i
);
  import dcache_pkg::*;

  logic                  vld_q;
  logic                  busy_q;
  mem_op_e               op_q;
  align_e                align_q;
  logic [`DC_ADDR_W-1:0] addr_q;
  logic [`DC_DATA_W-1:0] wdata_q;
  logic                  err_q;
  logic                  misalign;
  logic                  hit;
  logic                  rsp_fire;
  logic [`DC_DATA_W-1:0] word;
  logic [`DC_DATA_W-1:0] ld_shift;
  logic [`DC_DATA_W-1:0] ld_data;
  logic [`DC_DATA_W-1:0] st_shift;

  // halfword needs even address, word needs multiple of four
  always_comb begin
    case (req_align_i)
      AL_H, AL_HU: misalign = req_addr_i[0];
      AL_W:        misalign = |req_addr_i[1:0];
      default:     misalign = 1'b0;
    endcase
  end

  // ============================================================
  // lookup and handshake
  // ============================================================
  assign lookup_idx_o = addr_q[`DC_OFS_W +: `DC_IDX_W];
  assign hit          = line_valid_i & (line_tag_i == addr_q[`DC_ADDR_W-1 -: `DC_TAG_W]);
  // no answer while a refill for this request is outstanding
  assign rsp_valid_o  = vld_q & ~busy_q & (err_q | hit);
  assign rsp_fire     = rsp_valid_o & rsp_ready_i;
  assign req_ready_o  = ~vld_q | rsp_fire;
  assign miss_start_o = vld_q & ~err_q & ~hit & ~busy_q;
  assign miss_addr_o  = {addr_q[`DC_ADDR_W-1:`DC_OFS_W], {`DC_OFS_W{1'b0}}};

  // ============================================================
  // load extraction and store merge
  // ============================================================
  assign word     = line_data_i[addr_q[`DC_OFS_W-1:2]];
  assign ld_shift = word >> {addr_q[1:0], 3'b000};
  assign st_shift = wdata_q << {addr_q[1:0], 3'b000};

  always_comb begin
    case (align_q)
      AL_B:    ld_data = {{(`DC_DATA_W-8){ld_shift[7]}}, ld_shift[7:0]};
      AL_BU:   ld_data = {{(`DC_DATA_W-8){1'b0}}, ld_shift[7:0]};
      AL_H:    ld_data = {{(`DC_DATA_W-16){ld_shift[15]}}, ld_shift[15:0]};
      AL_HU:   ld_data = {{(`DC_DATA_W-16){1'b0}}, ld_shift[15:0]};
      default: ld_data = word;
    endcase
    case (align_q)
      AL_B, AL_BU: hit_be_o = (`DC_DATA_W/8)'(1) << addr_q[1:0];
      AL_H, AL_HU: hit_be_o = (`DC_DATA_W/8)'(3) << addr_q[1:0];
      default:     hit_be_o = '1;
    endcase
    // old bytes kept where the store does not reach
    for (int b = 0; b < `DC_DATA_W/8; b++) begin
      hit_wdata_o[8*b +: 8] = hit_be_o[b] ? st_shift[8*b +: 8] : word[8*b +: 8];
    end
  end

  assign rsp_rdata_o = (err_q | (op_q == OP_STORE)) ? '0 : ld_data;
  assign rsp_err_o   = err_q;
  assign hit_word_o  = addr_q[`DC_OFS_W-1:2];
  // store lands in the line only when its response goes out
  assign hit_we_o    = rsp_fire & (op_q == OP_STORE) & ~err_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      if (req_ready_o) begin
        vld_q <= req_valid_i;
      end
      if (miss_start_o) begin
        busy_q <= 1'b1;
      end else if (miss_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      op_q    <= req_op_i;
      align_q <= req_align_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      err_q   <= misalign;
    end
  end

endmodule

`default_nettype wire

/* logic/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  // load or store
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  // access size, U variants zero extend
  typedef enum logic [2:0] {
    AL_B  = 3'd0,
    AL_H  = 3'd1,
    AL_W  = 3'd2,
    AL_BU = 3'd3,
    AL_HU = 3'd4
  } align_e;

  // miss handling, write-back phases come first
  typedef enum logic [2:0] {
    MS_IDLE    = 3'd0,
    MS_WB_CMD  = 3'd1,
    MS_WB_DATA = 3'd2,
    MS_RF_CMD  = 3'd3,
    MS_RF_DATA = 3'd4
  } miss_state_e;

endpackage

`default_nettype wire

/* include/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ============================================================
// cache geometry
// ============================================================

// byte address and data word widths
`define DC_ADDR_W 32
`define DC_DATA_W 32

// line layout
`define DC_WORDS_PER_LINE 4
`define DC_LINES 16

// derived address split: tag | index | offset
`define DC_OFS_W ($clog2(`DC_WORDS_PER_LINE * (`DC_DATA_W / 8)))
`define DC_IDX_W ($clog2(`DC_LINES))
`define DC_TAG_W (`DC_ADDR_W - `DC_IDX_W - `DC_OFS_W)

// word select inside a line is the offset minus the byte bits
// so it is always `DC_OFS_W - 2 bits wide

`endif
